// File: rtl/lsq_pkg.sv
package lsq_pkg;

    // Datapath widths
    localparam int XLEN     = 32;
    localparam int ROB_W    = 4;   // Id 0 is reserved for "none"
    localparam int OFFSET_W = 12;

    // RISC-V func3 encodings for loads and stores
    typedef enum logic [2:0] {
        op_b  = 3'b000,
        op_h  = 3'b001,
        op_w  = 3'b010,
        op_bu = 3'b100,
        op_hu = 3'b101
    } mem_op_e;

    // Byte-serial access engine states
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_load  = 2'd1,
        st_store = 2'd2
    } access_state_e;

    // Number of bytes moved by an op, minus one
    function automatic logic [1:0] bytes_for_op(input mem_op_e op);
        case (op)
            op_b,
            op_bu:   return 2'd0;
            op_h,
            op_hu:   return 2'd1;
            default: return 2'd3;   // Word
        endcase
    endfunction

endpackage

// File: rtl/mem_rs.sv
module mem_rs
    import lsq_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                load_en,
    input  mem_op_e             load_op,
    input  logic [XLEN-1:0]     load_vj,
    input  logic [ROB_W-1:0]    load_qj,
    input  logic [ROB_W-1:0]    load_dest,
    input  logic [OFFSET_W-1:0] load_offset,
    input  logic                store_en,
    input  mem_op_e             store_op,
    input  logic [XLEN-1:0]     store_vj,
    input  logic [XLEN-1:0]     store_vk,
    input  logic [ROB_W-1:0]    store_qj,
    input  logic [ROB_W-1:0]    store_qk,
    input  logic [ROB_W-1:0]    store_dest,
    input  logic [OFFSET_W-1:0] store_offset,
    input  logic [ROB_W-1:0]    alu_rob_id,
    input  logic [XLEN-1:0]     alu_value,
    input  logic [ROB_W-1:0]    cdb_rob_id,
    input  logic [XLEN-1:0]     cdb_value,
    input  logic                recv,
    output logic                load_full,
    output logic                store_full,
    output logic                iss_store,
    output mem_op_e             iss_op,
    output logic [XLEN-1:0]     iss_base,
    output logic [XLEN-1:0]     iss_data,
    output logic [OFFSET_W-1:0] iss_offset,
    output logic [ROB_W-1:0]    iss_rob
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    // Load entries
    logic [RS_DEPTH-1:0] ld_busy;
    mem_op_e             ld_op     [RS_DEPTH];
    logic [XLEN-1:0]     ld_vj     [RS_DEPTH];
    logic [ROB_W-1:0]    ld_qj     [RS_DEPTH];
    logic [ROB_W-1:0]    ld_tag    [RS_DEPTH];   // Older store not yet handed on
    logic [ROB_W-1:0]    ld_dest   [RS_DEPTH];
    logic [OFFSET_W-1:0] ld_offset [RS_DEPTH];

    // Store entries
    logic [RS_DEPTH-1:0] st_busy;
    mem_op_e             st_op     [RS_DEPTH];
    logic [XLEN-1:0]     st_vj     [RS_DEPTH];   // Base
    logic [XLEN-1:0]     st_vk     [RS_DEPTH];   // Data
    logic [ROB_W-1:0]    st_qj     [RS_DEPTH];
    logic [ROB_W-1:0]    st_qk     [RS_DEPTH];
    logic [ROB_W-1:0]    st_tag    [RS_DEPTH];
    logic [ROB_W-1:0]    st_dest   [RS_DEPTH];
    logic [OFFSET_W-1:0] st_offset [RS_DEPTH];

    logic [ROB_W-1:0]    last_store_tag;
    logic [ROB_W-1:0]    new_tag;
    logic                store_done;
    logic                issue_go;
    logic                load_take;
    logic                store_take;
    logic [RS_DEPTH-1:0] ld_ready;
    logic [RS_DEPTH-1:0] st_ready;
    logic                ld_any_ready;
    logic                st_any_ready;
    logic [IDX_W-1:0]    ld_free_idx;
    logic [IDX_W-1:0]    st_free_idx;
    logic [IDX_W-1:0]    ld_sel_idx;
    logic [IDX_W-1:0]    st_sel_idx;

    // Value after snooping both broadcasts
    function automatic logic [XLEN-1:0] fwd_val(input logic [ROB_W-1:0] q,
                                                 input logic [XLEN-1:0] v);
        if (q != '0 && q == alu_rob_id) return alu_value;
        if (q != '0 && q == cdb_rob_id) return cdb_value;
        return v;
    endfunction

    function automatic logic [ROB_W-1:0] fwd_q(input logic [ROB_W-1:0] q);
        if (q != '0 && (q == alu_rob_id || q == cdb_rob_id)) return '0;
        return q;
    endfunction

    assign load_full    = &ld_busy;
    assign store_full   = &st_busy;
    assign load_take    = load_en && !load_full;
    assign store_take   = store_en && !store_full && !load_take;   // Load wins
    assign store_done   = recv && iss_store;   // A store was handed on
    assign issue_go     = (iss_rob == '0) || recv;
    assign new_tag      = (store_done && last_store_tag == iss_rob) ? '0 : last_store_tag;
    assign ld_any_ready = |ld_ready;
    assign st_any_ready = |st_ready;

    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ld_ready[i] = ld_busy[i] && ld_qj[i] == '0 && ld_tag[i] == '0;
            st_ready[i] = st_busy[i] && st_qj[i] == '0 && st_qk[i] == '0 && st_tag[i] == '0;
        end
    end

    // Lowest index wins, so scan downwards
    always_comb begin
        ld_free_idx = '0;
        st_free_idx = '0;
        ld_sel_idx  = '0;
        st_sel_idx  = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ld_busy[i])  ld_free_idx = IDX_W'(i);
            if (!st_busy[i])  st_free_idx = IDX_W'(i);
            if (ld_ready[i])  ld_sel_idx  = IDX_W'(i);
            if (st_ready[i])  st_sel_idx  = IDX_W'(i);
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            ld_busy        <= '0;
            st_busy        <= '0;
            last_store_tag <= '0;
            iss_rob        <= '0;
        end else begin
            if (issue_go) begin
                if (ld_any_ready) begin
                    ld_busy[ld_sel_idx] <= 1'b0;
                    iss_rob             <= ld_dest[ld_sel_idx];
                end else if (st_any_ready) begin
                    st_busy[st_sel_idx] <= 1'b0;
                    iss_rob             <= st_dest[st_sel_idx];
                end else begin
                    iss_rob <= '0;   // Nothing to offer
                end
            end
            if (load_take)  ld_busy[ld_free_idx] <= 1'b1;
            if (store_take) st_busy[st_free_idx] <= 1'b1;
            last_store_tag <= store_take ? store_dest : new_tag;
        end
    end

    always_ff @(posedge clk_in) begin
        // Wakeup and store tag release
        for (int i = 0; i < RS_DEPTH; i++) begin
            ld_vj[i] <= fwd_val(ld_qj[i], ld_vj[i]);
            ld_qj[i] <= fwd_q(ld_qj[i]);
            st_vj[i] <= fwd_val(st_qj[i], st_vj[i]);
            st_qj[i] <= fwd_q(st_qj[i]);
            st_vk[i] <= fwd_val(st_qk[i], st_vk[i]);
            st_qk[i] <= fwd_q(st_qk[i]);
            if (store_done && ld_tag[i] == iss_rob) ld_tag[i] <= '0;
            if (store_done && st_tag[i] == iss_rob) st_tag[i] <= '0;
        end

        if (load_take) begin
            ld_op[ld_free_idx]     <= load_op;
            ld_vj[ld_free_idx]     <= fwd_val(load_qj, load_vj);
            ld_qj[ld_free_idx]     <= fwd_q(load_qj);
            ld_tag[ld_free_idx]    <= new_tag;
            ld_dest[ld_free_idx]   <= load_dest;
            ld_offset[ld_free_idx] <= load_offset;
        end
        if (store_take) begin
            st_op[st_free_idx]     <= store_op;
            st_vj[st_free_idx]     <= fwd_val(store_qj, store_vj);
            st_qj[st_free_idx]     <= fwd_q(store_qj);
            st_vk[st_free_idx]     <= fwd_val(store_qk, store_vk);
            st_qk[st_free_idx]     <= fwd_q(store_qk);
            st_tag[st_free_idx]    <= new_tag;
            st_dest[st_free_idx]   <= store_dest;
            st_offset[st_free_idx] <= store_offset;
        end

        // Issue register payload
        if (issue_go && ld_any_ready) begin
            iss_store  <= 1'b0;
            iss_op     <= ld_op[ld_sel_idx];
            iss_base   <= ld_vj[ld_sel_idx];
            iss_data   <= '0;
            iss_offset <= ld_offset[ld_sel_idx];
        end else if (issue_go && st_any_ready) begin
            iss_store  <= 1'b1;
            iss_op     <= st_op[st_sel_idx];
            iss_base   <= st_vj[st_sel_idx];
            iss_data   <= st_vk[st_sel_idx];
            iss_offset <= st_offset[st_sel_idx];
        end
    end

    // Offer must hold until the access engine accepts it
    a_offer_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
        (iss_rob != '0 && !recv) |=> $stable(iss_rob) && $stable(iss_base)
                                     && $stable(iss_store));

    a_load_room: assert property (@(posedge clk_in) disable iff (!rst_n)
        load_en |-> !load_full);

    a_store_room: assert property (@(posedge clk_in) disable iff (!rst_n)
        store_en |-> !store_full);

endmodule

// File: rtl/mem_access.sv
module mem_access
    import lsq_pkg::*;
(
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                iss_store,
    input  mem_op_e             iss_op,
    input  logic [XLEN-1:0]     iss_base,
    input  logic [XLEN-1:0]     iss_data,
    input  logic [OFFSET_W-1:0] iss_offset,
    input  logic [ROB_W-1:0]    iss_rob,
    input  logic [7:0]          mem_din,
    input  logic                mem_success,
    output logic                recv,
    output logic                mem_en,
    output logic                mem_wr,
    output logic [XLEN-1:0]     mem_addr,
    output logic [7:0]          mem_dout,
    output logic [ROB_W-1:0]    fin_rob,
    output logic                fin_store,
    output mem_op_e             fin_op,
    output logic [XLEN-1:0]     fin_data
);

    access_state_e    state;
    logic [1:0]       byte_cnt;      // Bytes left minus one
    logic [XLEN-1:0]  data_buf;      // Store data out, load data in
    logic [ROB_W-1:0] cur_rob;
    mem_op_e          cur_op;
    logic [XLEN-1:0]  offset_ext;
    logic [XLEN-1:0]  load_word;
    logic             take;
    logic             beat;
    logic             last_beat;

    assign offset_ext = {{(XLEN - OFFSET_W){iss_offset[OFFSET_W-1]}}, iss_offset};
    assign take       = (state == st_idle) && (iss_rob != '0);
    assign beat       = mem_en && mem_success;   // One byte moves this cycle
    assign last_beat  = beat && (byte_cnt == 2'd0);
    assign mem_dout   = mem_wr ? data_buf[7:0] : 8'h00;

    // Earlier bytes sit at the top of the buffer, the last one is on mem_din
    always_comb begin
        case (bytes_for_op(cur_op))
            2'd0:    load_word = {{(XLEN - 8){1'b0}}, mem_din};
            2'd1:    load_word = {{(XLEN - 16){1'b0}}, mem_din, data_buf[XLEN-1 -: 8]};
            default: load_word = {mem_din, data_buf[XLEN-1:8]};
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state   <= st_idle;
            mem_en  <= 1'b0;
            mem_wr  <= 1'b0;
            recv    <= 1'b0;
            fin_rob <= '0;
        end else begin
            recv    <= take;   // Accept pulse, one cycle
            fin_rob <= '0;
            case (state)
                st_idle: begin
                    if (take) begin
                        state  <= iss_store ? st_store : st_load;
                        mem_en <= 1'b1;
                        mem_wr <= iss_store;
                    end
                end
                st_load,
                st_store: begin
                    if (last_beat) begin
                        state   <= st_idle;
                        mem_en  <= 1'b0;
                        mem_wr  <= 1'b0;
                        fin_rob <= cur_rob;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (take) begin
            mem_addr <= iss_base + offset_ext;
            byte_cnt <= bytes_for_op(iss_op);
            data_buf <= iss_store ? iss_data : '0;
            cur_rob  <= iss_rob;
            cur_op   <= iss_op;
        end else if (beat) begin
            // Stores drain the low byte, loads fill from the top
            data_buf <= {(mem_wr ? 8'h00 : mem_din), data_buf[XLEN-1:8]};
            if (!last_beat) begin
                mem_addr <= mem_addr + XLEN'(1);
                byte_cnt <= byte_cnt - 2'd1;
            end
        end
        if (last_beat) begin
            fin_store <= mem_wr;
            fin_op    <= cur_op;
            fin_data  <= mem_wr ? '0 : load_word;
        end
    end

    a_wr_in_store: assert property (@(posedge clk_in) disable iff (!rst_n)
        mem_wr |-> state == st_store);

    // Each transfer lowers the count until the one at zero ends the access
    a_cnt_floor: assert property (@(posedge clk_in) disable iff (!rst_n)
        (state != st_idle && beat)
            |=> (state == st_idle || byte_cnt < $past(byte_cnt)));

endmodule

// File: rtl/load_format.sv
module load_format
    import lsq_pkg::*;
(
    input  logic             clk_in,
    input  logic             rst_n,
    input  logic [ROB_W-1:0] fin_rob,
    input  logic             fin_store,
    input  mem_op_e          fin_op,
    input  logic [XLEN-1:0]  fin_data,
    output logic [ROB_W-1:0] cdb_rob_id,
    output logic [XLEN-1:0]  cdb_value
);

    logic [XLEN-1:0] ext_value;

    // Extension by func3
    always_comb begin
        case (fin_op)
            op_b:    ext_value = {{(XLEN - 8){fin_data[7]}}, fin_data[7:0]};
            op_h:    ext_value = {{(XLEN - 16){fin_data[15]}}, fin_data[15:0]};
            op_bu:   ext_value = {{(XLEN - 8){1'b0}}, fin_data[7:0]};
            op_hu:   ext_value = {{(XLEN - 16){1'b0}}, fin_data[15:0]};
            default: ext_value = fin_data;   // Word passes through
        endcase
        if (fin_store) begin
            ext_value = '0;   // Stores carry no result
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            cdb_rob_id <= '0;
        end else begin
            cdb_rob_id <= fin_rob;
        end
    end

    always_ff @(posedge clk_in) begin
        cdb_value <= ext_value;
    end

endmodule

// File: rtl/lsu_top.sv
module lsu_top
    import lsq_pkg::*;
#(
    parameter int RS_DEPTH = 4
) (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                load_en,
    input  mem_op_e             load_op,
    input  logic [XLEN-1:0]     load_vj,
    input  logic [ROB_W-1:0]    load_qj,
    input  logic [ROB_W-1:0]    load_dest,
    input  logic [OFFSET_W-1:0] load_offset,
    input  logic                store_en,
    input  mem_op_e             store_op,
    input  logic [XLEN-1:0]     store_vj,
    input  logic [XLEN-1:0]     store_vk,
    input  logic [ROB_W-1:0]    store_qj,
    input  logic [ROB_W-1:0]    store_qk,
    input  logic [ROB_W-1:0]    store_dest,
    input  logic [OFFSET_W-1:0] store_offset,
    input  logic [ROB_W-1:0]    alu_rob_id,
    input  logic [XLEN-1:0]     alu_value,
    input  logic [7:0]          mem_din,
    input  logic                mem_success,
    output logic                load_full,
    output logic                store_full,
    output logic                mem_en,
    output logic                mem_wr,
    output logic [XLEN-1:0]     mem_addr,
    output logic [7:0]          mem_dout,
    output logic [ROB_W-1:0]    cdb_rob_id,
    output logic [XLEN-1:0]     cdb_value
);

    // Station to access engine
    logic                iss_store;
    mem_op_e             iss_op;
    logic [XLEN-1:0]     iss_base;
    logic [XLEN-1:0]     iss_data;
    logic [OFFSET_W-1:0] iss_offset;
    logic [ROB_W-1:0]    iss_rob;
    logic                recv;

    // Access engine to formatter
    logic [ROB_W-1:0]    fin_rob;
    logic                fin_store;
    mem_op_e             fin_op;
    logic [XLEN-1:0]     fin_data;

    mem_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) rs0 (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .load_en      (load_en),
        .load_op      (load_op),
        .load_vj      (load_vj),
        .load_qj      (load_qj),
        .load_dest    (load_dest),
        .load_offset  (load_offset),
        .store_en     (store_en),
        .store_op     (store_op),
        .store_vj     (store_vj),
        .store_vk     (store_vk),
        .store_qj     (store_qj),
        .store_qk     (store_qk),
        .store_dest   (store_dest),
        .store_offset (store_offset),
        .alu_rob_id   (alu_rob_id),
        .alu_value    (alu_value),
        .cdb_rob_id   (cdb_rob_id),   // Own memory broadcast fed back
        .cdb_value    (cdb_value),
        .recv         (recv),
        .load_full    (load_full),
        .store_full   (store_full),
        .iss_store    (iss_store),
        .iss_op       (iss_op),
        .iss_base     (iss_base),
        .iss_data     (iss_data),
        .iss_offset   (iss_offset),
        .iss_rob      (iss_rob)
    );

    mem_access acc0 (
        .clk_in      (clk_in),
        .rst_n       (rst_n),
        .iss_store   (iss_store),
        .iss_op      (iss_op),
        .iss_base    (iss_base),
        .iss_data    (iss_data),
        .iss_offset  (iss_offset),
        .iss_rob     (iss_rob),
        .mem_din     (mem_din),
        .mem_success (mem_success),
        .recv        (recv),
        .mem_en      (mem_en),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_dout    (mem_dout),
        .fin_rob     (fin_rob),
        .fin_store   (fin_store),
        .fin_op      (fin_op),
        .fin_data    (fin_data)
    );

    load_format fmt0 (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .fin_rob    (fin_rob),
        .fin_store  (fin_store),
        .fin_op     (fin_op),
        .fin_data   (fin_data),
        .cdb_rob_id (cdb_rob_id),
        .cdb_value  (cdb_value)
    );

endmodule

// File: tb/byte_mem_model.sv
module byte_mem_model #(
    parameter logic [31:0] SEED = 32'h8f2f
) (
    input  logic        clk_in,
    input  logic        stall_en,
    input  logic        mem_en,
    input  logic        mem_wr,
    input  logic [31:0] mem_addr,
    input  logic [7:0]  mem_dout,
    output logic [7:0]  mem_din,
    output logic        mem_success
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] mem [256];   // Indexed by the low address byte

    // Preset contents, every address bit takes part
    function automatic logic [7:0] fill_byte(input logic [7:0] a);
        return (a * 8'd37) ^ {a[3:0], a[7:4]} ^ 8'h5a;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_byte(8'(i));
        end
    end

    assign mem_din = mem[mem_addr[7:0]];   // Read data valid in the transfer cycle

    always @(posedge clk_in) begin
        if (mem_en && mem_wr && mem_success) begin
            mem[mem_addr[7:0]] <= mem_dout;
        end
    end

    // Roughly one stalled cycle in four while stalls are enabled
    initial begin
        mem_success = 1'b1;
        void'($urandom(SEED));
        forever begin
            @(posedge clk_in);
            mem_success <= stall_en ? (($urandom & 32'h3) != 32'h0) : 1'b1;
        end
    end

endmodule

// File: tb/tb_lsu.sv
module tb_lsu
    import lsq_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RS_DEPTH        = 4;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 2000;

    logic                clk_in = 1'b0;
    logic                rst_n;
    logic                load_en;
    mem_op_e             load_op;
    logic [XLEN-1:0]     load_vj;
    logic [ROB_W-1:0]    load_qj;
    logic [ROB_W-1:0]    load_dest;
    logic [OFFSET_W-1:0] load_offset;
    logic                store_en;
    mem_op_e             store_op;
    logic [XLEN-1:0]     store_vj;
    logic [XLEN-1:0]     store_vk;
    logic [ROB_W-1:0]    store_qj;
    logic [ROB_W-1:0]    store_qk;
    logic [ROB_W-1:0]    store_dest;
    logic [OFFSET_W-1:0] store_offset;
    logic [ROB_W-1:0]    alu_rob_id;
    logic [XLEN-1:0]     alu_value;
    logic [7:0]          mem_din;
    logic                mem_success;
    logic                load_full;
    logic                store_full;
    logic                mem_en;
    logic                mem_wr;
    logic [XLEN-1:0]     mem_addr;
    logic [7:0]          mem_dout;
    logic [ROB_W-1:0]    cdb_rob_id;
    logic [XLEN-1:0]     cdb_value;
    logic                stall_en;

    // Scoreboard, one slot per ROB id
    logic [XLEN-1:0]     exp_val   [1 << ROB_W];
    logic                exp_valid [1 << ROB_W];
    logic [7:0]          shadow    [256];
    int                  pending;

    always #4 clk_in = ~clk_in;

    lsu_top #(
        .RS_DEPTH (RS_DEPTH)
    ) dut0 (
        .clk_in       (clk_in),
        .rst_n        (rst_n),
        .load_en      (load_en),
        .load_op      (load_op),
        .load_vj      (load_vj),
        .load_qj      (load_qj),
        .load_dest    (load_dest),
        .load_offset  (load_offset),
        .store_en     (store_en),
        .store_op     (store_op),
        .store_vj     (store_vj),
        .store_vk     (store_vk),
        .store_qj     (store_qj),
        .store_qk     (store_qk),
        .store_dest   (store_dest),
        .store_offset (store_offset),
        .alu_rob_id   (alu_rob_id),
        .alu_value    (alu_value),
        .mem_din      (mem_din),
        .mem_success  (mem_success),
        .load_full    (load_full),
        .store_full   (store_full),
        .mem_en       (mem_en),
        .mem_wr       (mem_wr),
        .mem_addr     (mem_addr),
        .mem_dout     (mem_dout),
        .cdb_rob_id   (cdb_rob_id),
        .cdb_value    (cdb_value)
    );

    byte_mem_model #(
        .SEED (32'h8f2f)
    ) mem0 (
        .clk_in      (clk_in),
        .stall_en    (stall_en),
        .mem_en      (mem_en),
        .mem_wr      (mem_wr),
        .mem_addr    (mem_addr),
        .mem_dout    (mem_dout),
        .mem_din     (mem_din),
        .mem_success (mem_success)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
        assert (got === exp)
            else fail_run($sformatf("** Error at %0d ns: %s got %h expected %h",
                                    $time, name, got, exp));
    endtask

    function automatic logic [XLEN-1:0] eff_addr(input logic [XLEN-1:0] base,
                                                 input logic [OFFSET_W-1:0] off);
        return base + {{(XLEN - OFFSET_W){off[OFFSET_W-1]}}, off};
    endfunction

    // Little-endian read of the shadow bytes, then extension by func3
    function automatic logic [XLEN-1:0] load_expect(input mem_op_e op,
                                                    input logic [XLEN-1:0] addr);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = shadow[addr[7:0]];
        b1 = shadow[addr[7:0] + 8'd1];
        b2 = shadow[addr[7:0] + 8'd2];
        b3 = shadow[addr[7:0] + 8'd3];
        case (op)
            op_b:    return {{24{b0[7]}}, b0};
            op_bu:   return {24'h0, b0};
            op_h:    return {{16{b1[7]}}, b1, b0};
            op_hu:   return {16'h0, b1, b0};
            default: return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic void store_apply(input mem_op_e op, input logic [XLEN-1:0] addr,
                                        input logic [XLEN-1:0] data);
        shadow[addr[7:0]] = data[7:0];
        if (op != op_b) begin
            shadow[addr[7:0] + 8'd1] = data[15:8];
        end
        if (op == op_w) begin
            shadow[addr[7:0] + 8'd2] = data[23:16];
            shadow[addr[7:0] + 8'd3] = data[31:24];
        end
    endfunction

    // base is the final base value; bc_id nonzero also broadcasts it on the ALU bus
    task automatic dispatch_load(input mem_op_e op, input logic [XLEN-1:0] base,
                                 input logic [ROB_W-1:0] qj, input logic [ROB_W-1:0] dest,
                                 input logic [OFFSET_W-1:0] off,
                                 input logic [ROB_W-1:0] bc_id);
        @(negedge clk_in);
        while (load_full) @(negedge clk_in);
        @(posedge clk_in);
        load_en     <= 1'b1;
        load_op     <= op;
        load_vj     <= (qj == '0) ? base : 32'hdead_beef;   // Junk while tagged
        load_qj     <= qj;
        load_dest   <= dest;
        load_offset <= off;
        alu_rob_id  <= bc_id;
        alu_value   <= base;
        exp_val[dest]   = load_expect(op, eff_addr(base, off));
        exp_valid[dest] = 1'b1;
        pending         = pending + 1;
        @(posedge clk_in);
        load_en    <= 1'b0;
        alu_rob_id <= '0;
    endtask

    task automatic dispatch_store(input mem_op_e op, input logic [XLEN-1:0] base,
                                  input logic [XLEN-1:0] data, input logic [ROB_W-1:0] qk,
                                  input logic [ROB_W-1:0] dest,
                                  input logic [OFFSET_W-1:0] off);
        @(negedge clk_in);
        while (store_full) @(negedge clk_in);
        @(posedge clk_in);
        store_en     <= 1'b1;
        store_op     <= op;
        store_vj     <= base;
        store_qj     <= '0;
        store_vk     <= (qk == '0) ? data : 32'hbad0_da7a;
        store_qk     <= qk;
        store_dest   <= dest;
        store_offset <= off;
        store_apply(op, eff_addr(base, off), data);   // Program order
        exp_val[dest]   = '0;
        exp_valid[dest] = 1'b1;
        pending         = pending + 1;
        @(posedge clk_in);
        store_en <= 1'b0;
    endtask

    task automatic alu_broadcast(input logic [ROB_W-1:0] id, input logic [XLEN-1:0] val);
        @(posedge clk_in);
        alu_rob_id <= id;
        alu_value  <= val;
        @(posedge clk_in);
        alu_rob_id <= '0;
    endtask

    task automatic wait_done();
        @(negedge clk_in);
        while (pending != 0) @(negedge clk_in);
        repeat (2) @(negedge clk_in);
    endtask

    task automatic test_reset();
        @(negedge clk_in);
        check_val("cdb_rob_id", 32'(cdb_rob_id), 32'd0);
        check_val("mem_en", 32'(mem_en), 32'd0);
        check_val("mem_wr", 32'(mem_wr), 32'd0);
        check_val("load_full", 32'(load_full), 32'd0);
        check_val("store_full", 32'(store_full), 32'd0);
    endtask

    task automatic test_load_widths();
        dispatch_load(op_b,  32'h0000_0080, '0, 4'd1, 12'hff3, '0);   // Negative offset
        dispatch_load(op_bu, 32'h0000_0080, '0, 4'd2, 12'hff4, '0);
        dispatch_load(op_h,  32'h0000_0010, '0, 4'd3, 12'h024, '0);
        dispatch_load(op_hu, 32'h0000_0010, '0, 4'd4, 12'h037, '0);
        dispatch_load(op_w,  32'h0000_00c0, '0, 4'd5, 12'hfe3, '0);
        dispatch_load(op_bu, 32'h0000_0000, '0, 4'd6, 12'h0f7, '0);
        wait_done();
    endtask

    // Store data waits on tag 10, the load behind it must wait too
    task automatic store_then_load(input mem_op_e st_op, input mem_op_e ld_op,
                                   input logic [OFFSET_W-1:0] off,
                                   input logic [XLEN-1:0] data);
        dispatch_store(st_op, 32'h0000_0050, data, 4'd10, 4'd1, off);
        dispatch_load(ld_op, 32'h0000_0050, '0, 4'd2, off, '0);
        repeat (12) @(negedge clk_in);
        assert (pending == 2)
            else fail_run("An operation completed before the store data was broadcast");
        alu_broadcast(4'd10, data);
        wait_done();
    endtask

    task automatic test_store_load();
        store_then_load(op_b, op_b,  12'h003, 32'h0000_00f1);
        store_then_load(op_h, op_hu, 12'h009, 32'h0000_9c37);
        store_then_load(op_w, op_w,  12'hff8, 32'h8a5c_e3f1);
    endtask

    task automatic test_base_wakeup();
        dispatch_load(op_w, 32'h0000_0044, 4'd11, 4'd3, 12'h004, '0);
        repeat (12) @(negedge clk_in);
        assert (pending == 1)
            else fail_run("Load with a pending base completed before its ALU broadcast");
        alu_broadcast(4'd11, 32'h0000_0044);
        wait_done();
        dispatch_load(op_h, 32'h0000_0061, 4'd12, 4'd4, 12'hffd, 4'd12);   // Same cycle
        wait_done();
    endtask

    task automatic test_full_stalls();
        @(posedge clk_in);
        stall_en <= 1'b1;
        dispatch_store(op_w, 32'h0000_00a0, 32'hc001_d00d, '0, 4'd1, 12'h000);
        dispatch_store(op_h, 32'h0000_00a0, 32'h0000_8e42, '0, 4'd2, 12'h006);
        dispatch_load(op_w,  32'h0000_00a0, 4'd9, 4'd3, 12'h000, '0);
        dispatch_load(op_hu, 32'h0000_00a0, 4'd9, 4'd4, 12'h006, '0);
        dispatch_load(op_b,  32'h0000_00a0, 4'd9, 4'd5, 12'h007, '0);
        dispatch_load(op_h,  32'h0000_00a0, 4'd9, 4'd6, 12'hff0, '0);
        @(negedge clk_in);
        check_val("load_full", 32'(load_full), 32'd1);
        dispatch_store(op_b, 32'h0000_0030, 32'h0000_007e, '0, 4'd7, 12'h002);
        alu_broadcast(4'd9, 32'h0000_00a0);
        wait_done();
        @(posedge clk_in);
        stall_en <= 1'b0;
    endtask

    // Every broadcast must be expected, and only once
    always @(posedge clk_in) begin
        if (rst_n === 1'b1 && cdb_rob_id != '0) begin
            assert (exp_valid[cdb_rob_id])
                else fail_run($sformatf("Unexpected broadcast of ROB id %0d at %0d ns",
                                        cdb_rob_id, $time));
            assert (cdb_value === exp_val[cdb_rob_id])
                else fail_run($sformatf(
                    "** Error at %0d ns: cdb_value (ROB id %0d) got %h expected %h",
                    $time, cdb_rob_id, cdb_value, exp_val[cdb_rob_id]));
            exp_valid[cdb_rob_id] = 1'b0;
            pending = pending - 1;
        end
    end

    // Test addresses stay inside the 256 modeled bytes
    always @(posedge clk_in) begin
        if (rst_n === 1'b1 && mem_en && mem_success) begin
            check_val("mem_addr[31:8]", 32'(mem_addr[31:8]), 32'd0);
            if (mem_wr) begin
                check_val("mem_dout", 32'(mem_dout), 32'(shadow[mem_addr[7:0]]));
            end
        end
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk_in);
        fail_run($sformatf("Timeout after %0d cycles", NUM_TESTS * CYCLES_PER_TEST));
    end

    initial begin
        rst_n        = 1'b0;
        load_en      = 1'b0;
        load_op      = op_w;
        load_vj      = '0;
        load_qj      = '0;
        load_dest    = '0;
        load_offset  = '0;
        store_en     = 1'b0;
        store_op     = op_w;
        store_vj     = '0;
        store_vk     = '0;
        store_qj     = '0;
        store_qk     = '0;
        store_dest   = '0;
        store_offset = '0;
        alu_rob_id   = '0;
        alu_value    = '0;
        stall_en     = 1'b0;
        pending      = 0;
        for (int i = 0; i < (1 << ROB_W); i++) begin
            exp_valid[i] = 1'b0;
        end
        repeat (4) @(posedge clk_in);
        rst_n <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = mem0.mem[i];   // Start from the preset memory image
        end

        test_reset();
        test_load_widths();
        test_store_load();
        test_base_wakeup();
        test_full_stalls();

        if (pending != 0) begin
            fail_run("Operations were left without a broadcast at the end of the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// File: all.f
rtl/lsq_pkg.sv
rtl/mem_rs.sv
rtl/mem_access.sv
rtl/load_format.sv
rtl/lsu_top.sv
tb/byte_mem_model.sv
tb/tb_lsu.sv

// File: Makefile
# Verilator flow for the load/store unit

VERILATOR  ?= verilator
TOP        ?= tb_lsu
RTL_TOP    ?= lsu_top
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
